/* Bender.yml */
package:
  name: control_unit

sources:
  - files:
      - source/datapath_ctrl_pkg.sv
      - source/riscv_isa_pkg.sv
      - source/instr_decoder.sv
      - source/control_fsm.sv
      - source/control_encoder.sv
      - source/control_unit.sv
  - target: test
    files:
      - tests/control_unit_properties.sv
      - tests/control_unit_tb.sv

/* control_unit.f */
source/datapath_ctrl_pkg.sv
source/riscv_isa_pkg.sv
source/instr_decoder.sv
source/control_fsm.sv
source/control_encoder.sv
source/control_unit.sv
tests/control_unit_properties.sv
tests/control_unit_tb.sv

/* source/control_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module control_encoder (
    input  datapath_ctrl_pkg::ctrl_state_t state,
    input  riscv_isa_pkg::decoded_instr_t  decoded,
    input  datapath_ctrl_pkg::alu_flags_t  flags,
    output datapath_ctrl_pkg::ctrl_word_t  ctrl
);

    logic taken;

    always_comb begin
        case (decoded.branch_cond)
            riscv_isa_pkg::br_eq: taken = flags.zero;
            riscv_isa_pkg::br_ne: taken = !flags.zero;
            riscv_isa_pkg::br_ge: taken = !flags.less;
            default:              taken = flags.less;  // blt
        endcase
    end

    always_comb begin
        ctrl = datapath_ctrl_pkg::ctrl_idle;
        case (state)
            datapath_ctrl_pkg::st_reset: ctrl.datapath_reset = 1'b1;
            datapath_ctrl_pkg::st_fetch: begin
                ctrl.ir_load   = 1'b1;
                ctrl.pc_write  = 1'b1;  // pc + 4
                ctrl.alu_op    = datapath_ctrl_pkg::alu_add;
                ctrl.alu_b_sel = datapath_ctrl_pkg::b_four;
            end
            datapath_ctrl_pkg::st_decode: begin
                ctrl.ab_write      = 1'b1;
                ctrl.alu_out_write = 1'b1;  // branch target into alu_out
                ctrl.alu_op        = datapath_ctrl_pkg::alu_add;
                ctrl.alu_b_sel     = datapath_ctrl_pkg::b_imm_shifted;
            end
            datapath_ctrl_pkg::st_execute: begin
                ctrl.alu_op    = decoded.alu_op;
                ctrl.alu_a_sel = datapath_ctrl_pkg::a_reg;
                ctrl.alu_b_sel = datapath_ctrl_pkg::b_imm;
                case (decoded.cls)
                    riscv_isa_pkg::cls_rtype: begin
                        ctrl.alu_out_write = 1'b1;
                        ctrl.alu_b_sel     = datapath_ctrl_pkg::b_reg;
                    end
                    riscv_isa_pkg::cls_imm,
                    riscv_isa_pkg::cls_load,
                    riscv_isa_pkg::cls_store,
                    riscv_isa_pkg::cls_jalr: ctrl.alu_out_write = 1'b1;
                    riscv_isa_pkg::cls_lui: begin
                        ctrl.alu_out_write = 1'b1;
                        ctrl.alu_a_sel     = datapath_ctrl_pkg::a_zero;
                    end
                    riscv_isa_pkg::cls_branch: begin
                        ctrl.alu_b_sel = datapath_ctrl_pkg::b_reg;
                        ctrl.pc_write  = taken;
                        ctrl.pc_src    = datapath_ctrl_pkg::pc_alu_out;
                    end
                    default: ctrl.alu_op = datapath_ctrl_pkg::alu_nop;  // nop, break
                endcase
            end
            datapath_ctrl_pkg::st_alu_write,
            datapath_ctrl_pkg::st_lui_write: ctrl.reg_write = 1'b1;
            datapath_ctrl_pkg::st_set_one: begin
                ctrl.reg_write    = 1'b1;
                ctrl.reg_data_sel = datapath_ctrl_pkg::rd_one;
            end
            datapath_ctrl_pkg::st_set_zero: begin
                ctrl.reg_write    = 1'b1;
                ctrl.reg_data_sel = datapath_ctrl_pkg::rd_zero;
            end
            datapath_ctrl_pkg::st_link: begin
                ctrl.reg_write    = 1'b1;
                ctrl.reg_data_sel = datapath_ctrl_pkg::rd_pc;  // rd = pc + 4
                ctrl.pc_write     = 1'b1;
                ctrl.pc_src       = datapath_ctrl_pkg::pc_alu_out;
            end
            // partial stores merge with the old word, so stores read first
            datapath_ctrl_pkg::st_load_read,
            datapath_ctrl_pkg::st_store_addr: ctrl.mem_data_reg_write = 1'b1;
            datapath_ctrl_pkg::st_load_write: begin
                ctrl.reg_write = 1'b1;
                case (decoded.load_width)
                    riscv_isa_pkg::load_d:  ctrl.reg_data_sel = datapath_ctrl_pkg::rd_ld;
                    riscv_isa_pkg::load_b:  ctrl.reg_data_sel = datapath_ctrl_pkg::rd_lb;
                    riscv_isa_pkg::load_h:  ctrl.reg_data_sel = datapath_ctrl_pkg::rd_lh;
                    riscv_isa_pkg::load_w:  ctrl.reg_data_sel = datapath_ctrl_pkg::rd_lw;
                    riscv_isa_pkg::load_bu: ctrl.reg_data_sel = datapath_ctrl_pkg::rd_lbu;
                    riscv_isa_pkg::load_hu: ctrl.reg_data_sel = datapath_ctrl_pkg::rd_lhu;
                    default:                ctrl.reg_data_sel = datapath_ctrl_pkg::rd_lwu;
                endcase
            end
            datapath_ctrl_pkg::st_store_write: begin
                ctrl.mem_write   = 1'b1;
                ctrl.store_width = decoded.store_width;
            end
            default: ;  // wait, halt and memory latency states stay idle
        endcase
    end

endmodule

`default_nettype wire

/* source/control_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module control_fsm (
    input  wire logic                          CLK,
    input  wire logic                          RST,
    input  riscv_isa_pkg::decoded_instr_t      decoded,
    input  datapath_ctrl_pkg::alu_flags_t      flags,
    output datapath_ctrl_pkg::ctrl_state_t     state
);

    datapath_ctrl_pkg::ctrl_state_t next_state;
    datapath_ctrl_pkg::ctrl_state_t exec_next;

    always_ff @(posedge CLK, posedge RST) begin
        if (RST) begin
            state <= datapath_ctrl_pkg::st_reset;
        end else begin
            state <= next_state;
        end
    end

    // successor of execute, by class
    always_comb begin
        case (decoded.cls)
            riscv_isa_pkg::cls_rtype,
            riscv_isa_pkg::cls_imm: begin
                if (!decoded.is_slt) begin
                    exec_next = datapath_ctrl_pkg::st_alu_write;
                end else if (flags.less) begin
                    exec_next = datapath_ctrl_pkg::st_set_one;
                end else begin
                    exec_next = datapath_ctrl_pkg::st_set_zero;
                end
            end
            riscv_isa_pkg::cls_load:   exec_next = datapath_ctrl_pkg::st_load_addr;
            riscv_isa_pkg::cls_store:  exec_next = datapath_ctrl_pkg::st_store_addr;
            riscv_isa_pkg::cls_branch: exec_next = datapath_ctrl_pkg::st_wait;
            riscv_isa_pkg::cls_jalr:   exec_next = datapath_ctrl_pkg::st_link;
            riscv_isa_pkg::cls_lui:    exec_next = datapath_ctrl_pkg::st_lui_write;
            riscv_isa_pkg::cls_break:  exec_next = datapath_ctrl_pkg::st_halt;
            default:                   exec_next = datapath_ctrl_pkg::st_fetch;  // nop
        endcase
    end

    always_comb begin
        case (state)
            datapath_ctrl_pkg::st_reset:       next_state = datapath_ctrl_pkg::st_wait;
            datapath_ctrl_pkg::st_wait:        next_state = datapath_ctrl_pkg::st_fetch;
            datapath_ctrl_pkg::st_fetch:       next_state = datapath_ctrl_pkg::st_decode;
            datapath_ctrl_pkg::st_decode:      next_state = datapath_ctrl_pkg::st_execute;
            datapath_ctrl_pkg::st_execute:     next_state = exec_next;
            datapath_ctrl_pkg::st_load_addr:   next_state = datapath_ctrl_pkg::st_load_read;
            datapath_ctrl_pkg::st_load_read:   next_state = datapath_ctrl_pkg::st_load_write;
            datapath_ctrl_pkg::st_store_addr:  next_state = datapath_ctrl_pkg::st_store_wait;
            datapath_ctrl_pkg::st_store_wait:  next_state = datapath_ctrl_pkg::st_store_write;
            datapath_ctrl_pkg::st_halt:        next_state = datapath_ctrl_pkg::st_halt;
            default:                           next_state = datapath_ctrl_pkg::st_wait;
        endcase
    end

endmodule

`default_nettype wire

/* source/control_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  wire logic                                  CLK,
    input  wire logic                                  RST,
    input  wire logic [riscv_isa_pkg::instr_width-1:0] instr,
    input  datapath_ctrl_pkg::alu_flags_t              flags,
    output datapath_ctrl_pkg::ctrl_word_t              ctrl
);

    riscv_isa_pkg::decoded_instr_t  decoded;
    datapath_ctrl_pkg::ctrl_state_t state;

    instr_decoder u_decoder (
        .instr   (instr),
        .decoded (decoded)
    );

    control_fsm u_fsm (
        .CLK     (CLK),
        .RST     (RST),
        .decoded (decoded),
        .flags   (flags),
        .state   (state)
    );

    control_encoder u_encoder (
        .state   (state),
        .decoded (decoded),
        .flags   (flags),
        .ctrl    (ctrl)
    );

endmodule

`default_nettype wire

/* source/datapath_ctrl_pkg.sv */
`default_nettype none

package datapath_ctrl_pkg;

    typedef enum logic [2:0] {
        alu_nop    = 3'b000,
        alu_add    = 3'b001,
        alu_sub    = 3'b010,
        alu_and    = 3'b011,
        alu_cmp_ge = 3'b101,
        alu_slt    = 3'b110
    } alu_op_t;

    typedef enum logic [1:0] {
        a_pc   = 2'b00,
        a_reg  = 2'b01,
        a_zero = 2'b11  // lui path
    } alu_a_sel_t;

    typedef enum logic [2:0] {
        b_reg         = 3'b000,
        b_four        = 3'b001,
        b_imm         = 3'b010,
        b_imm_shifted = 3'b011  // branch offset, imm << 1
    } alu_b_sel_t;

    typedef enum logic [1:0] {
        pc_alu_out = 2'b00,
        pc_alu     = 2'b01
    } pc_src_t;

    typedef enum logic [3:0] {
        rd_alu_out = 4'b0000,
        rd_one     = 4'b0010,
        rd_zero    = 4'b0011,
        rd_pc      = 4'b0100,
        rd_ld      = 4'b0101,
        rd_lb      = 4'b0110,
        rd_lh      = 4'b0111,
        rd_lw      = 4'b1000,
        rd_lbu     = 4'b1001,
        rd_lhu     = 4'b1010,
        rd_lwu     = 4'b1011
    } reg_data_sel_t;

    typedef enum logic [4:0] {
        st_reset,
        st_wait,
        st_fetch,
        st_decode,
        st_execute,
        st_alu_write,
        st_set_one,
        st_set_zero,
        st_link,
        st_lui_write,
        st_load_addr,
        st_load_read,
        st_load_write,
        st_store_addr,
        st_store_wait,
        st_store_write,
        st_halt
    } ctrl_state_t;

    typedef struct packed {
        logic zero;
        logic less;  // signed a < b
    } alu_flags_t;

    typedef struct packed {
        logic          datapath_reset;
        logic          pc_write;
        pc_src_t       pc_src;
        logic          ir_load;
        logic          ab_write;
        logic          alu_out_write;
        alu_op_t       alu_op;
        alu_a_sel_t    alu_a_sel;
        alu_b_sel_t    alu_b_sel;
        logic          reg_write;
        reg_data_sel_t reg_data_sel;
        logic          mem_data_reg_write;
        logic          mem_write;
        logic [1:0]    store_width;  // store size mux code
    } ctrl_word_t;

    localparam ctrl_word_t ctrl_idle = '{
        datapath_reset:     1'b0,
        pc_write:           1'b0,
        pc_src:             pc_alu,
        ir_load:            1'b0,
        ab_write:           1'b0,
        alu_out_write:      1'b0,
        alu_op:             alu_nop,
        alu_a_sel:          a_pc,
        alu_b_sel:          b_reg,
        reg_write:          1'b0,
        reg_data_sel:       rd_alu_out,
        mem_data_reg_write: 1'b0,
        mem_write:          1'b0,
        store_width:        2'b00
    };

endpackage

`default_nettype wire

/* source/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  wire logic [riscv_isa_pkg::instr_width-1:0] instr,
    output riscv_isa_pkg::decoded_instr_t              decoded
);

    riscv_isa_pkg::opcode_t opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        decoded.cls         = riscv_isa_pkg::cls_nop;  // unknown opcodes fall through
        decoded.alu_op      = datapath_ctrl_pkg::alu_add;
        decoded.load_width  = riscv_isa_pkg::load_d;
        decoded.store_width = riscv_isa_pkg::store_d;
        decoded.branch_cond = riscv_isa_pkg::br_eq;
        decoded.is_slt      = 1'b0;
        case (opcode)
            riscv_isa_pkg::op_rtype: begin
                decoded.cls = riscv_isa_pkg::cls_rtype;
                if (funct7 == riscv_isa_pkg::funct7_sub) begin
                    decoded.alu_op = datapath_ctrl_pkg::alu_sub;
                end else if (funct3 == riscv_isa_pkg::f3_and) begin
                    decoded.alu_op = datapath_ctrl_pkg::alu_and;
                end else if (funct3 == riscv_isa_pkg::f3_slt) begin
                    decoded.alu_op = datapath_ctrl_pkg::alu_slt;
                    decoded.is_slt = 1'b1;
                end else if (funct3 != riscv_isa_pkg::f3_add) begin
                    decoded.cls = riscv_isa_pkg::cls_nop;
                end
            end
            riscv_isa_pkg::op_imm: begin
                if (instr[31:7] != '0 && funct3 == riscv_isa_pkg::f3_add) begin
                    decoded.cls = riscv_isa_pkg::cls_imm;  // addi
                end else if (funct3 == riscv_isa_pkg::f3_slt) begin
                    decoded.cls    = riscv_isa_pkg::cls_imm;
                    decoded.alu_op = datapath_ctrl_pkg::alu_slt;
                    decoded.is_slt = 1'b1;
                end
            end
            riscv_isa_pkg::op_load: begin
                decoded.cls = riscv_isa_pkg::cls_load;
                case (funct3)
                    riscv_isa_pkg::f3_ld:  decoded.load_width = riscv_isa_pkg::load_d;
                    riscv_isa_pkg::f3_lb:  decoded.load_width = riscv_isa_pkg::load_b;
                    riscv_isa_pkg::f3_lh:  decoded.load_width = riscv_isa_pkg::load_h;
                    riscv_isa_pkg::f3_lw:  decoded.load_width = riscv_isa_pkg::load_w;
                    riscv_isa_pkg::f3_lbu: decoded.load_width = riscv_isa_pkg::load_bu;
                    riscv_isa_pkg::f3_lhu: decoded.load_width = riscv_isa_pkg::load_hu;
                    riscv_isa_pkg::f3_lwu: decoded.load_width = riscv_isa_pkg::load_wu;
                    default:               decoded.cls        = riscv_isa_pkg::cls_nop;
                endcase
            end
            riscv_isa_pkg::op_store: begin
                decoded.cls = riscv_isa_pkg::cls_store;
                case (funct3)
                    riscv_isa_pkg::f3_sd: decoded.store_width = riscv_isa_pkg::store_d;
                    riscv_isa_pkg::f3_sw: decoded.store_width = riscv_isa_pkg::store_w;
                    riscv_isa_pkg::f3_sh: decoded.store_width = riscv_isa_pkg::store_h;
                    riscv_isa_pkg::f3_sb: decoded.store_width = riscv_isa_pkg::store_b;
                    default:              decoded.cls         = riscv_isa_pkg::cls_nop;
                endcase
            end
            riscv_isa_pkg::op_branch: begin
                decoded.cls    = riscv_isa_pkg::cls_branch;
                decoded.alu_op = datapath_ctrl_pkg::alu_sub;  // zero and less from a - b
                case (funct3)
                    riscv_isa_pkg::f3_beq: decoded.branch_cond = riscv_isa_pkg::br_eq;
                    riscv_isa_pkg::f3_bne: decoded.branch_cond = riscv_isa_pkg::br_ne;
                    riscv_isa_pkg::f3_blt: decoded.branch_cond = riscv_isa_pkg::br_lt;
                    riscv_isa_pkg::f3_bge: begin
                        decoded.branch_cond = riscv_isa_pkg::br_ge;
                        decoded.alu_op      = datapath_ctrl_pkg::alu_cmp_ge;
                    end
                    default: decoded.cls = riscv_isa_pkg::cls_nop;
                endcase
            end
            riscv_isa_pkg::op_jalr:   decoded.cls = riscv_isa_pkg::cls_jalr;
            riscv_isa_pkg::op_lui:    decoded.cls = riscv_isa_pkg::cls_lui;
            riscv_isa_pkg::op_system: decoded.cls = riscv_isa_pkg::cls_break;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    localparam int xlen        = 64;
    localparam int instr_width = 32;

    typedef logic [6:0] opcode_t;

    localparam opcode_t op_rtype  = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_system = 7'b1110011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_ld  = 3'b011;
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_lwu = 3'b110;
    localparam logic [2:0] f3_sd  = 3'b111;  // sd encoding of this core
    localparam logic [2:0] f3_sw  = 3'b010;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam logic [6:0] funct7_sub = 7'b0100000;

    typedef enum logic [3:0] {
        cls_rtype, cls_imm, cls_load, cls_store, cls_branch,
        cls_jalr, cls_lui, cls_nop, cls_break
    } instr_class_t;

    typedef enum logic [2:0] {
        load_d, load_b, load_h, load_w, load_bu, load_hu, load_wu
    } load_width_t;

    typedef enum logic [1:0] {store_d, store_w, store_h, store_b} store_width_t;

    typedef enum logic [1:0] {br_eq, br_ne, br_ge, br_lt} branch_cond_t;

    typedef struct packed {
        instr_class_t               cls;
        datapath_ctrl_pkg::alu_op_t alu_op;
        load_width_t                load_width;
        store_width_t               store_width;
        branch_cond_t               branch_cond;
        logic                       is_slt;  // slt or slti
    } decoded_instr_t;

endpackage

`default_nettype wire

/* tests/control_unit_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit_properties (
    input wire logic                     CLK,
    input wire logic                     RST,
    input datapath_ctrl_pkg::ctrl_word_t ctrl
);

    int unsigned fail_count = 0;
    logic        any_write;

    assign any_write = ctrl.pc_write || ctrl.ir_load || ctrl.ab_write || ctrl.alu_out_write
                    || ctrl.reg_write || ctrl.mem_data_reg_write || ctrl.mem_write;

    fetch_moves_pc: assert property (@(posedge CLK) disable iff (RST)
        ctrl.ir_load |-> ctrl.pc_write)
    else begin
        fail_count++;
        $error("ir_load without pc_write");
    end

    writes_exclusive: assert property (@(posedge CLK) disable iff (RST)
        !(ctrl.mem_write && ctrl.reg_write))
    else begin
        fail_count++;
        $error("mem_write and reg_write in the same cycle");
    end

    reset_quiet: assert property (@(posedge CLK) ctrl.datapath_reset |-> !any_write)
    else begin
        fail_count++;
        $error("write strobe during datapath reset");
    end

    // datapath_reset only in the first cycle after RST
    reset_once: assert property (@(posedge CLK) disable iff (RST)
        ctrl.datapath_reset |-> $past(RST))
    else begin
        fail_count++;
        $error("datapath_reset outside the first cycle after reset");
    end

endmodule

bind control_unit control_unit_properties u_props (
    .CLK  (CLK),
    .RST  (RST),
    .ctrl (ctrl)
);

`default_nettype wire

/* tests/control_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit_tb;

    // reset, 6 alu, 4 slt, 16 branch, 11 memory, 2 nop, break window, then margin
    localparam int max_cycles = 5 + 6*5 + 4*5 + 16*4 + 11*7 + 2*3 + 22 + 100;

    logic                             CLK;
    logic                             RST;
    logic [31:0]                      instr;
    datapath_ctrl_pkg::alu_flags_t    flags;
    datapath_ctrl_pkg::ctrl_word_t    ctrl;
    int unsigned                      cycles = 0;
    int unsigned                      errors = 0;
    int unsigned                      test_base = 0;
    int unsigned                      tests_run = 0;
    int unsigned                      tests_failed = 0;
    int                               spacing;
    int                               reg_writes;
    int                               mem_writes;
    int                               pc_writes;  // outside fetch
    logic                             halted;
    datapath_ctrl_pkg::alu_op_t       exec_alu_op;
    datapath_ctrl_pkg::reg_data_sel_t wr_sel;
    logic [1:0]                       st_width;

    control_unit uut (.CLK(CLK), .RST(RST), .instr(instr), .flags(flags), .ctrl(ctrl));

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles == max_cycles) begin
            $display("timeout after %0d cycles, the DUT stopped issuing instructions", cycles);
            $display("Test failed");
            $finish;
        end
    end

    halt_holds: assert property (@(posedge CLK) halted |-> !ctrl.ir_load)
        else mismatch("ir_load after break");

    task automatic mismatch(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic int unsigned total_errors();
        return errors + uut.u_props.fail_count;
    endfunction

    function automatic logic [31:0] encode_rtype(input logic [6:0] f7, input logic [2:0] f3);
        logic [31:0] w;
        w = $urandom;
        return {f7, w[24:15], f3, w[11:7], riscv_isa_pkg::op_rtype};
    endfunction

    function automatic logic [31:0] encode_word(input logic [6:0] op, input logic [2:0] f3);
        logic [31:0] w;
        w = $urandom;
        return {w[31:15], f3, w[11:8], 1'b1, op};  // rd never zero
    endfunction

    // caller sits on a falling edge with ir_load high
    task automatic run_instr(input logic [31:0] word, input logic zero, input logic less);
        instr = word;
        flags.zero = zero;
        flags.less = less;
        spacing = 0;
        reg_writes = 0;
        mem_writes = 0;
        pc_writes = 0;
        do begin
            @(negedge CLK);
            spacing++;
            if (spacing == 2) exec_alu_op = ctrl.alu_op;
            if (ctrl.reg_write) begin
                reg_writes++;
                wr_sel = ctrl.reg_data_sel;
            end
            if (ctrl.mem_write) begin
                mem_writes++;
                st_width = ctrl.store_width;
            end
            if (ctrl.pc_write && !ctrl.ir_load) pc_writes++;
            assert (!ctrl.pc_write || ctrl.ir_load
                    || ctrl.pc_src == datapath_ctrl_pkg::pc_alu_out)
                else mismatch($sformatf("pc_write with pc_src %0d", ctrl.pc_src));
        end while (!ctrl.ir_load);
        assert (ctrl.alu_op == datapath_ctrl_pkg::alu_add
                && ctrl.alu_b_sel == datapath_ctrl_pkg::b_four)
            else mismatch($sformatf("fetch alu_op %0d, alu_b_sel %0d",
                                    ctrl.alu_op, ctrl.alu_b_sel));
    endtask

    task automatic check_counts(input string name, input int sp, input int rw, input int mw);
        assert (spacing == sp)
            else mismatch($sformatf("%s ir_load spacing %0d, expected %0d", name, spacing, sp));
        assert (reg_writes == rw)
            else mismatch($sformatf("%s reg_write count %0d, expected %0d", name, reg_writes, rw));
        assert (mem_writes == mw)
            else mismatch($sformatf("%s mem_write count %0d, expected %0d", name, mem_writes, mw));
    endtask

    task automatic check_alu_instr(input string name, input datapath_ctrl_pkg::alu_op_t op);
        check_counts(name, 5, 1, 0);
        assert (exec_alu_op == op)
            else mismatch($sformatf("%s alu_op %0d, expected %0d", name, exec_alu_op, op));
        assert (wr_sel == datapath_ctrl_pkg::rd_alu_out && pc_writes == 0)
            else mismatch($sformatf("%s writes sel %0d, pc_write %0d", name, wr_sel, pc_writes));
    endtask

    task automatic end_test(input string name);
        int unsigned now;
        now = total_errors();
        if (now == test_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, now - test_base);
            tests_failed++;
        end
        tests_run++;
        test_base = now;
    endtask

    initial begin
        logic [2:0]                       load_f3 [7];
        datapath_ctrl_pkg::reg_data_sel_t load_sel [7];
        logic [2:0]                       store_f3 [4];
        logic [1:0]                       store_sel [4];
        logic [2:0]                       br_f3 [4];
        logic                             taken;
        load_f3 = '{riscv_isa_pkg::f3_ld, riscv_isa_pkg::f3_lb, riscv_isa_pkg::f3_lh,
                    riscv_isa_pkg::f3_lw, riscv_isa_pkg::f3_lbu, riscv_isa_pkg::f3_lhu,
                    riscv_isa_pkg::f3_lwu};
        load_sel = '{datapath_ctrl_pkg::rd_ld, datapath_ctrl_pkg::rd_lb, datapath_ctrl_pkg::rd_lh,
                     datapath_ctrl_pkg::rd_lw, datapath_ctrl_pkg::rd_lbu,
                     datapath_ctrl_pkg::rd_lhu, datapath_ctrl_pkg::rd_lwu};
        store_f3 = '{riscv_isa_pkg::f3_sd, riscv_isa_pkg::f3_sw, riscv_isa_pkg::f3_sh,
                     riscv_isa_pkg::f3_sb};
        store_sel = '{riscv_isa_pkg::store_d, riscv_isa_pkg::store_w, riscv_isa_pkg::store_h,
                      riscv_isa_pkg::store_b};
        br_f3 = '{riscv_isa_pkg::f3_beq, riscv_isa_pkg::f3_bne, riscv_isa_pkg::f3_bge,
                  riscv_isa_pkg::f3_blt};
        void'($urandom(32'h9dbc));
        RST = 1'b1;
        instr = 32'h0000_0013;
        flags = '0;
        halted = 1'b0;

        repeat (3) @(negedge CLK);
        assert (ctrl.datapath_reset && !ctrl.ir_load && !ctrl.pc_write && !ctrl.reg_write
                && !ctrl.mem_write) else mismatch("control word during reset");
        RST = 1'b0;
        spacing = 0;
        do begin
            @(negedge CLK);
            spacing++;
        end while (!ctrl.ir_load);
        assert (spacing == 2) else mismatch($sformatf("first ir_load after %0d cycles", spacing));
        end_test("reset");

        run_instr(encode_rtype(7'h00, riscv_isa_pkg::f3_add), 1'b0, 1'b0);
        check_alu_instr("add", datapath_ctrl_pkg::alu_add);
        run_instr(encode_rtype(riscv_isa_pkg::funct7_sub, riscv_isa_pkg::f3_add), 1'b0, 1'b1);
        check_alu_instr("sub", datapath_ctrl_pkg::alu_sub);
        run_instr(encode_rtype(7'h00, riscv_isa_pkg::f3_and), 1'b1, 1'b0);
        check_alu_instr("and", datapath_ctrl_pkg::alu_and);
        run_instr(encode_word(riscv_isa_pkg::op_imm, riscv_isa_pkg::f3_add), 1'b0, 1'b1);
        check_alu_instr("addi", datapath_ctrl_pkg::alu_add);
        run_instr(encode_word(riscv_isa_pkg::op_lui, 3'($urandom)), 1'b0, 1'b0);
        check_alu_instr("lui", datapath_ctrl_pkg::alu_add);
        run_instr(encode_word(riscv_isa_pkg::op_jalr, 3'b000), 1'b0, 1'b0);
        check_counts("jalr", 5, 1, 0);
        assert (pc_writes == 1 && wr_sel == datapath_ctrl_pkg::rd_pc
                && exec_alu_op == datapath_ctrl_pkg::alu_add)
            else mismatch($sformatf("jalr pc_write %0d, reg_data_sel %0d, alu_op %0d",
                                    pc_writes, wr_sel, exec_alu_op));
        end_test("alu");

        for (int i = 0; i < 4; i++) begin
            run_instr(i[1] ? encode_word(riscv_isa_pkg::op_imm, riscv_isa_pkg::f3_slt)
                           : encode_rtype(7'h00, riscv_isa_pkg::f3_slt), 1'b0, i[0]);
            check_counts("slt", 5, 1, 0);
            assert (wr_sel == (i[0] ? datapath_ctrl_pkg::rd_one : datapath_ctrl_pkg::rd_zero))
                else mismatch($sformatf("slt less=%0d wrote sel %0d", i[0], wr_sel));
        end
        end_test("slt");

        for (int b = 0; b < 4; b++) begin
            for (int f = 0; f < 4; f++) begin
                case (b)
                    0: taken = f[0];  // eq on zero
                    1: taken = !f[0];
                    2: taken = !f[1];  // ge on less
                    default: taken = f[1];
                endcase
                run_instr(encode_word(riscv_isa_pkg::op_branch, br_f3[b]), f[0], f[1]);
                check_counts("branch", 4, 0, 0);
                assert (pc_writes == int'(taken))
                    else mismatch($sformatf("branch %0d zero=%0d less=%0d pc_write %0d",
                                            b, f[0], f[1], pc_writes));
            end
        end
        end_test("branch");

        for (int i = 0; i < 7; i++) begin
            run_instr(encode_word(riscv_isa_pkg::op_load, load_f3[i]), 1'b0, 1'b0);
            check_counts("load", 7, 1, 0);
            assert (wr_sel == load_sel[i])
                else mismatch($sformatf("load %0d extend code %0d", i, wr_sel));
        end
        for (int i = 0; i < 4; i++) begin
            run_instr(encode_word(riscv_isa_pkg::op_store, store_f3[i]), 1'b0, 1'b0);
            check_counts("store", 7, 0, 1);
            assert (st_width == store_sel[i])
                else mismatch($sformatf("store %0d store_width %0d", i, st_width));
        end
        end_test("memory");

        run_instr(32'h0000_0013, 1'b0, 1'b0);
        check_counts("nop", 3, 0, 0);
        run_instr(32'h0000_000b, 1'b1, 1'b1);  // custom-0, not decoded
        check_counts("unknown", 3, 0, 0);
        assert (pc_writes == 0) else mismatch("pc_write on unknown opcode");
        instr = 32'h0010_0073;
        @(negedge CLK);
        halted = 1'b1;
        spacing = 0;
        repeat (20) begin
            @(negedge CLK);
            if (ctrl.ir_load) spacing++;
        end
        assert (spacing == 0) else mismatch($sformatf("%0d ir_load pulses after break", spacing));
        end_test("nop and break");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
